// File: common/cfg_port_consts.svh
`ifndef CFG_PORT_CONSTS_SVH
`define CFG_PORT_CONSTS_SVH

// Bus widths
`define CFG_DATA_W 128
`define CFG_ADDR_W 40
`define CFG_ID_W 1
`define CFG_LEN_W 8

// One beat is always the full 16 byte lanes
`define CFG_LANES 16
// Word index starts above the byte offset
`define CFG_ADDR_LSB 4

// Memory geometry, one beat per row
`define CFG_ROWS 4
// Address bit that selects the status word instead of a row
`define CFG_STATUS_BIT 6

// AXI burst encodings
`define CFG_BURST_FIXED 2'b00
`define CFG_BURST_INCR 2'b01
`define CFG_BURST_WRAP 2'b10

// Only OKAY is ever returned
`define CFG_RESP_OKAY 2'b00

`endif

// File: common/cfg_port_pkg.sv
`default_nettype none

`include "cfg_port_consts.svh"

package cfg_port_pkg;

	// ----------------------------------------------------------------------
	// AXI4 channel payloads, valid and ready travel as separate wires
	// ----------------------------------------------------------------------

	// Write address command
	typedef struct packed
	{
		logic [`CFG_ID_W-1:0] id;
		logic [`CFG_ADDR_W-1:0] addr;
		logic [`CFG_LEN_W-1:0] len;
		logic [1:0] burst;
	} axi_aw_t;

	// Write data beat, strb has one bit per byte lane
	typedef struct packed
	{
		logic [`CFG_DATA_W-1:0] data;
		logic [`CFG_LANES-1:0] strb;
		logic last;
	} axi_w_t;

	// Write response
	typedef struct packed
	{
		logic [`CFG_ID_W-1:0] id;
		logic [1:0] resp;
	} axi_b_t;

	// Read address command, same fields as the write side
	// Kept as its own type so the two channels cannot be crossed
	typedef struct packed
	{
		logic [`CFG_ID_W-1:0] id;
		logic [`CFG_ADDR_W-1:0] addr;
		logic [`CFG_LEN_W-1:0] len;
		logic [1:0] burst;
	} axi_ar_t;

	// Read data beat
	typedef struct packed
	{
		logic [`CFG_ID_W-1:0] id;
		logic [`CFG_DATA_W-1:0] data;
		logic [1:0] resp;
		logic last;
	} axi_r_t;

	// One memory row, written by byte lane and read back whole
	typedef union packed
	{
		logic [`CFG_DATA_W-1:0] word;
		logic [`CFG_LANES-1:0][7:0] bytes;
	} cfg_word_u;

endpackage

`default_nettype wire

// File: design/burst_addr_gen.sv
`timescale 1ns/10ps
`default_nettype none

`include "cfg_port_consts.svh"

module burst_addr_gen
(
	input wire logic S_AXI_ACLK,
	input wire logic S_AXI_ARESETN,
	input wire logic load,
	input wire logic step,
	input wire cfg_port_pkg::axi_aw_t cmd,
	output logic [`CFG_ADDR_W-1:0] addr,
	output logic last_beat
);

	// Latched burst command
	logic [`CFG_ADDR_W-1:0] addr_q;
	logic [`CFG_LEN_W-1:0] len_q;
	logic [1:0] burst_q;
	// Beats already stepped past
	logic [`CFG_LEN_W-1:0] cnt_q;

	logic [`CFG_ADDR_W-1:0] wrap_size;
	logic [`CFG_ADDR_W-1:0] incr_addr;
	logic [`CFG_ADDR_W-1:0] next_addr;

	// Wrap size is len beats of 16 bytes
	assign wrap_size = {{(`CFG_ADDR_W-`CFG_LEN_W-`CFG_ADDR_LSB){1'b0}}, len_q,
		{`CFG_ADDR_LSB{1'b0}}};

	// Next word, byte offset dropped
	assign incr_addr = {addr_q[`CFG_ADDR_W-1:`CFG_ADDR_LSB] + 1'b1, {`CFG_ADDR_LSB{1'b0}}};

	always_comb
	begin
		case (burst_q)
			`CFG_BURST_FIXED:
				next_addr = addr_q;
			`CFG_BURST_WRAP:
			begin
				// Fall back by the wrap size once every covered bit is set
				if ((addr_q & wrap_size) == wrap_size)
					next_addr = addr_q - wrap_size;
				else
					next_addr = incr_addr;
			end
			// INCR and the reserved code both count up
			default:
				next_addr = incr_addr;
		endcase
	end

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
		begin
			addr_q <= '0;
			len_q <= '0;
			burst_q <= `CFG_BURST_INCR;
			cnt_q <= '0;
		end
		else if (load)
		begin
			addr_q <= cmd.addr;
			len_q <= cmd.len;
			burst_q <= cmd.burst;
			cnt_q <= '0;
		end
		else if (step)
		begin
			addr_q <= next_addr;
			cnt_q <= cnt_q + 1'b1;
		end
	end

	assign addr = addr_q;
	assign last_beat = (cnt_q == len_q);

	// Controller must stop stepping on the final beat until the next command
	a_no_step_past_last: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		step && !load |-> !last_beat)
		else $error("burst_addr_gen stepped past the last beat");

endmodule

`default_nettype wire

// File: design/cfg_port_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module cfg_port_ctrl
(
	input wire logic S_AXI_ACLK,
	input wire logic S_AXI_ARESETN,
	input wire logic aw_valid,
	output logic aw_ready,
	input wire logic w_valid,
	input wire logic w_last,
	output logic w_ready,
	output logic b_valid,
	input wire logic b_ready,
	input wire logic ar_valid,
	output logic ar_ready,
	output logic r_valid,
	input wire logic r_ready,
	output logic r_last,
	output logic wr_load,
	output logic wr_step,
	output logic rd_load,
	output logic rd_step,
	output logic wr_en,
	output logic rd_en,
	input wire logic rd_last_beat
);

	// One transaction at a time, write or read
	typedef enum logic [2:0]
	{
		ST_IDLE,
		ST_WR_ADDR,
		ST_WR_DATA,
		ST_WR_RESP,
		ST_RD_ADDR,
		ST_RD_WAIT,
		ST_RD_BEAT
	} state_t;

	state_t state_q;
	state_t state_d;
	logic w_ready_q;
	// Handshakes completing this cycle
	logic w_beat_ok;
	logic r_beat_ok;

	assign w_beat_ok = w_ready_q && w_valid;
	assign r_beat_ok = r_valid && r_ready;

	// ----------------------------------------------------------------------
	// Next state
	// ----------------------------------------------------------------------
	always_comb
	begin
		state_d = state_q;
		case (state_q)
			ST_IDLE:
			begin
				// Write wins when both addresses show up together
				if (aw_valid)
					state_d = ST_WR_ADDR;
				else if (ar_valid)
					state_d = ST_RD_ADDR;
			end
			ST_WR_ADDR:
				state_d = ST_WR_DATA;
			ST_WR_DATA:
			begin
				if (w_beat_ok && w_last)
					state_d = ST_WR_RESP;
			end
			ST_WR_RESP:
			begin
				// Stay busy until the response is taken
				if (b_ready)
					state_d = ST_IDLE;
			end
			ST_RD_ADDR:
				state_d = ST_RD_WAIT;
			// Memory registers the beat here
			ST_RD_WAIT:
				state_d = ST_RD_BEAT;
			ST_RD_BEAT:
			begin
				if (r_ready)
					state_d = rd_last_beat ? ST_IDLE : ST_RD_WAIT;
			end
			default:
				state_d = ST_IDLE;
		endcase
	end

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
		begin
			state_q <= ST_IDLE;
			w_ready_q <= 1'b0;
		end
		else
		begin
			state_q <= state_d;
			// W ready follows w_valid by a cycle and drops after the last beat
			if (w_beat_ok && w_last)
				w_ready_q <= 1'b0;
			else if (state_q == ST_WR_DATA && w_valid)
				w_ready_q <= 1'b1;
		end
	end

	// ----------------------------------------------------------------------
	// Handshake outputs and strobes
	// ----------------------------------------------------------------------
	assign aw_ready = (state_q == ST_WR_ADDR);
	assign wr_load = (state_q == ST_WR_ADDR);
	assign w_ready = w_ready_q;
	assign wr_en = w_beat_ok;
	// No step on the final beat, the generator holds there
	assign wr_step = w_beat_ok && !w_last;
	assign b_valid = (state_q == ST_WR_RESP);

	assign ar_ready = (state_q == ST_RD_ADDR);
	assign rd_load = (state_q == ST_RD_ADDR);
	// Capture once per beat so the data holds under back-pressure
	assign rd_en = (state_q == ST_RD_WAIT);
	assign r_valid = (state_q == ST_RD_BEAT);
	assign r_last = r_valid && rd_last_beat;
	assign rd_step = r_beat_ok && !rd_last_beat;

	a_one_response: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		!(b_valid && r_valid))
		else $error("write response and read data valid together");

	a_r_hold: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		r_valid && !r_ready |=> r_valid)
		else $error("r_valid dropped without r_ready");

endmodule

`default_nettype wire

// File: cfg_ram/cfg_ram.sv
`timescale 1ns/10ps
`default_nettype none

`include "cfg_port_consts.svh"

module cfg_ram
(
	input wire logic S_AXI_ACLK,
	input wire logic S_AXI_ARESETN,
	input wire logic wr_en,
	input wire logic [`CFG_ADDR_W-1:0] wr_addr,
	input wire cfg_port_pkg::axi_w_t wr_beat,
	input wire logic rd_en,
	input wire logic [`CFG_ADDR_W-1:0] rd_addr,
	input wire logic [`CFG_DATA_W-1:0] status_in,
	output cfg_port_pkg::cfg_word_u rd_word,
	output logic [`CFG_ROWS*`CFG_DATA_W-1:0] memory_out
);

	import cfg_port_pkg::*;

	// Row 0 in the low bits so the export is a plain copy
	cfg_word_u [`CFG_ROWS-1:0] rows_q;

	logic [$clog2(`CFG_ROWS)-1:0] wr_row;
	logic [$clog2(`CFG_ROWS)-1:0] rd_row;

	// Row index sits just above the byte offset
	assign wr_row = wr_addr[`CFG_ADDR_LSB +: $clog2(`CFG_ROWS)];
	assign rd_row = rd_addr[`CFG_ADDR_LSB +: $clog2(`CFG_ROWS)];

	// ----------------------------------------------------------------------
	// Byte-strobed write
	// ----------------------------------------------------------------------
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			rows_q <= '0;
		// Status region is read-only, writes there are dropped
		else if (wr_en && !wr_addr[`CFG_STATUS_BIT])
		begin
			for (int i = 0; i < `CFG_LANES; i++)
			begin
				if (wr_beat.strb[i])
					rows_q[wr_row].bytes[i] <= wr_beat.data[8*i +: 8];
			end
		end
	end

	// ----------------------------------------------------------------------
	// Registered read, status word above the rows
	// ----------------------------------------------------------------------
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (rd_en)
		begin
			if (rd_addr[`CFG_STATUS_BIT])
				rd_word.word <= status_in;
			else
				rd_word.word <= rows_q[rd_row].word;
		end
	end

	assign memory_out = rows_q;

	a_rows_quiet: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		!wr_en |=> $stable(rows_q))
		else $error("configuration row changed without a write beat");

endmodule

`default_nettype wire

// File: design/cfg_port_top.sv
`timescale 1ns/10ps
`default_nettype none

`include "cfg_port_consts.svh"

module cfg_port_top
(
	input wire logic S_AXI_ACLK,
	input wire logic S_AXI_ARESETN,
	// Write address
	input wire cfg_port_pkg::axi_aw_t aw_cmd,
	input wire logic aw_valid,
	output logic aw_ready,
	// Write data
	input wire cfg_port_pkg::axi_w_t w_beat,
	input wire logic w_valid,
	output logic w_ready,
	// Write response
	output cfg_port_pkg::axi_b_t b_resp,
	output logic b_valid,
	input wire logic b_ready,
	// Read address
	input wire cfg_port_pkg::axi_ar_t ar_cmd,
	input wire logic ar_valid,
	output logic ar_ready,
	// Read data
	output cfg_port_pkg::axi_r_t r_beat,
	output logic r_valid,
	input wire logic r_ready,
	// Side band
	input wire logic [`CFG_DATA_W-1:0] status_in,
	output logic [`CFG_ROWS*`CFG_DATA_W-1:0] memory_out
);

	import cfg_port_pkg::*;

	logic wr_load;
	logic wr_step;
	logic rd_load;
	logic rd_step;
	logic wr_en;
	logic rd_en;
	logic r_last;
	logic rd_last_beat;
	logic [`CFG_ADDR_W-1:0] wr_addr;
	logic [`CFG_ADDR_W-1:0] rd_addr;
	axi_aw_t rd_cmd;
	cfg_word_u rd_word;
	// IDs echoed on B and R
	logic [`CFG_ID_W-1:0] wr_id_q;
	logic [`CFG_ID_W-1:0] rd_id_q;

	// Read command goes through the shared generator field by field
	assign rd_cmd = '{id: ar_cmd.id, addr: ar_cmd.addr, len: ar_cmd.len, burst: ar_cmd.burst};

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
		begin
			wr_id_q <= '0;
			rd_id_q <= '0;
		end
		else
		begin
			if (wr_load)
				wr_id_q <= aw_cmd.id;
			if (rd_load)
				rd_id_q <= ar_cmd.id;
		end
	end

	assign b_resp = '{id: wr_id_q, resp: `CFG_RESP_OKAY};
	// Data bus reads zero between beats
	assign r_beat = '{id: rd_id_q, data: (r_valid ? rd_word.word : {`CFG_DATA_W{1'b0}}),
		resp: `CFG_RESP_OKAY, last: r_last};

	cfg_port_ctrl cfg_port_ctrl_i
	(
		.S_AXI_ACLK(S_AXI_ACLK), .S_AXI_ARESETN(S_AXI_ARESETN),
		.aw_valid(aw_valid), .aw_ready(aw_ready),
		.w_valid(w_valid), .w_last(w_beat.last), .w_ready(w_ready),
		.b_valid(b_valid), .b_ready(b_ready),
		.ar_valid(ar_valid), .ar_ready(ar_ready),
		.r_valid(r_valid), .r_ready(r_ready), .r_last(r_last),
		.wr_load(wr_load), .wr_step(wr_step), .rd_load(rd_load), .rd_step(rd_step),
		.wr_en(wr_en), .rd_en(rd_en), .rd_last_beat(rd_last_beat)
	);

	// Write side only needs the address, W last closes the burst
	burst_addr_gen wr_gen
	(
		.S_AXI_ACLK(S_AXI_ACLK), .S_AXI_ARESETN(S_AXI_ARESETN),
		.load(wr_load), .step(wr_step), .cmd(aw_cmd), .addr(wr_addr), .last_beat()
	);

	burst_addr_gen rd_gen
	(
		.S_AXI_ACLK(S_AXI_ACLK), .S_AXI_ARESETN(S_AXI_ARESETN),
		.load(rd_load), .step(rd_step), .cmd(rd_cmd), .addr(rd_addr),
		.last_beat(rd_last_beat)
	);

	cfg_ram cfg_ram_i
	(
		.S_AXI_ACLK(S_AXI_ACLK), .S_AXI_ARESETN(S_AXI_ARESETN),
		.wr_en(wr_en), .wr_addr(wr_addr), .wr_beat(w_beat),
		.rd_en(rd_en), .rd_addr(rd_addr), .status_in(status_in),
		.rd_word(rd_word), .memory_out(memory_out)
	);

endmodule

`default_nettype wire

// File: verif/tb_cfg_port.sv
`timescale 1ns/10ps
`default_nettype none

`include "cfg_port_consts.svh"

module tb_cfg_port;

	import cfg_port_pkg::*;

	logic S_AXI_ACLK = 1'b0;
	logic S_AXI_ARESETN;
	axi_aw_t aw_cmd;
	logic aw_valid;
	logic aw_ready;
	axi_w_t w_beat;
	logic w_valid;
	logic w_ready;
	axi_b_t b_resp;
	logic b_valid;
	logic b_ready;
	axi_ar_t ar_cmd;
	logic ar_valid;
	logic ar_ready;
	axi_r_t r_beat;
	logic r_valid;
	logic r_ready;
	logic [`CFG_DATA_W-1:0] status_in;
	logic [`CFG_ROWS*`CFG_DATA_W-1:0] memory_out;

	// Expected memory image with row 0 in the low bits
	logic [`CFG_ROWS*`CFG_DATA_W-1:0] mem_model;
	// Payload of the next write burst
	logic [`CFG_DATA_W-1:0] wr_data [0:7];
	logic [`CFG_LANES-1:0] wr_strb [0:7];
	logic [31:0] lfsr;
	logic write_busy = 1'b0;
	int err_count = 0;
	int cycle_count = 0;

	cfg_port_top cfg_port_top_i
	(
		.S_AXI_ACLK(S_AXI_ACLK), .S_AXI_ARESETN(S_AXI_ARESETN),
		.aw_cmd(aw_cmd), .aw_valid(aw_valid), .aw_ready(aw_ready),
		.w_beat(w_beat), .w_valid(w_valid), .w_ready(w_ready),
		.b_resp(b_resp), .b_valid(b_valid), .b_ready(b_ready),
		.ar_cmd(ar_cmd), .ar_valid(ar_valid), .ar_ready(ar_ready),
		.r_beat(r_beat), .r_valid(r_valid), .r_ready(r_ready),
		.status_in(status_in), .memory_out(memory_out)
	);

	// 4 ns clock
	always #2 S_AXI_ACLK = ~S_AXI_ACLK;

	// Run limit of about ten times the whole test sequence
	always @(posedge S_AXI_ACLK)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count == 3000)
		begin
			$display("timeout: the DUT stopped answering after %0d cycles", cycle_count);
			$display("test failed");
			$finish;
		end
	end

	// ----------------------------------------------------------------------
	// Stimulus helpers
	// ----------------------------------------------------------------------

	// Galois LFSR for x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	// One LFSR step per bit
	task automatic rand_word(output logic [`CFG_DATA_W-1:0] w);
		for (int i = 0; i < `CFG_DATA_W; i++)
		begin
			lfsr = lfsr_next(lfsr);
			w[i] = lfsr[0];
		end
	endtask

	function automatic axi_aw_t make_cmd(input logic id, input logic [`CFG_ADDR_W-1:0] a,
		input logic [`CFG_LEN_W-1:0] len, input logic [1:0] burst);
		return '{id: id, addr: a, len: len, burst: burst};
	endfunction

	// Next beat address by burst type
	// WRAP falls back by 16*len once the covered bits are all set
	function automatic logic [`CFG_ADDR_W-1:0] step_addr(input logic [`CFG_ADDR_W-1:0] a,
		input logic [`CFG_LEN_W-1:0] len, input logic [1:0] burst);
		logic [`CFG_ADDR_W-1:0] wsize;
		wsize = `CFG_ADDR_W'(len) << 4;
		if (burst == `CFG_BURST_FIXED)
			return a;
		if (burst == `CFG_BURST_WRAP && (a & wsize) == wsize)
			return a - wsize;
		return (a & ~`CFG_ADDR_W'(15)) + 16;
	endfunction

	// Status word above the rows and the row from bits 5:4 below
	function automatic logic [`CFG_DATA_W-1:0] expect_data(input logic [`CFG_ADDR_W-1:0] a);
		int row;
		row = a[5:4];
		if (a[`CFG_STATUS_BIT])
			return status_in;
		return mem_model[row*`CFG_DATA_W +: `CFG_DATA_W];
	endfunction

	task automatic report(input string msg);
		err_count++;
		$display("error at %0t ns: %s", $time, msg);
	endtask

	task automatic check_b(input axi_b_t got, input axi_b_t exp);
		if (got !== exp)
			report($sformatf("write response got %h expected %h", got, exp));
	endtask

	task automatic check_r(input axi_r_t got, input axi_r_t exp);
		if (got !== exp)
			report($sformatf("read beat got %h expected %h", got, exp));
	endtask

	task automatic check_mem(input logic [`CFG_ROWS*`CFG_DATA_W-1:0] got);
		if (got !== mem_model)
			report($sformatf("memory_out got %h expected %h", got, mem_model));
	endtask

	// Wait for the next edge and 1 ns more for drive and sampling
	task automatic tick();
		@(posedge S_AXI_ACLK);
		#1;
		if (b_valid && r_valid)
			report("write response and read data valid in the same cycle");
		if (ar_ready && write_busy)
			report("read address accepted while a write was in progress");
	endtask

	// ----------------------------------------------------------------------
	// Bus transactions
	// ----------------------------------------------------------------------
	task automatic write_burst(input axi_aw_t cmd);
		logic [`CFG_ADDR_W-1:0] a;
		int row;
		a = cmd.addr;
		write_busy = 1'b1;
		aw_cmd = cmd;
		aw_valid = 1'b1;
		while (!aw_ready)
			tick();
		tick();
		aw_valid = 1'b0;
		for (int i = 0; i <= cmd.len; i++)
		begin
			w_beat = '{data: wr_data[i], strb: wr_strb[i], last: (i == cmd.len)};
			w_valid = 1'b1;
			while (!w_ready)
				tick();
			tick();
			// Status region takes no writes
			row = a[5:4];
			for (int l = 0; l < `CFG_LANES; l++)
			begin
				if (wr_strb[i][l] && !a[`CFG_STATUS_BIT])
					mem_model[row*`CFG_DATA_W + 8*l +: 8] = wr_data[i][8*l +: 8];
			end
			a = step_addr(a, cmd.len, cmd.burst);
		end
		w_valid = 1'b0;
		while (!b_valid)
			tick();
		check_b(b_resp, '{id: cmd.id, resp: `CFG_RESP_OKAY});
		b_ready = 1'b1;
		tick();
		b_ready = 1'b0;
		write_busy = 1'b0;
		if (b_valid)
			report("b_valid stayed high after the response was taken");
	endtask

	// hold is the number of cycles each beat waits with r_ready low
	task automatic read_burst(input axi_aw_t cmd, input int hold);
		logic [`CFG_ADDR_W-1:0] a;
		axi_r_t exp;
		a = cmd.addr;
		ar_cmd = '{id: cmd.id, addr: cmd.addr, len: cmd.len, burst: cmd.burst};
		ar_valid = 1'b1;
		while (!ar_ready)
			tick();
		tick();
		ar_valid = 1'b0;
		for (int i = 0; i <= cmd.len; i++)
		begin
			while (!r_valid)
				tick();
			exp = '{id: cmd.id, data: expect_data(a), resp: `CFG_RESP_OKAY,
				last: (i == cmd.len)};
			check_r(r_beat, exp);
			for (int h = 0; h < hold; h++)
			begin
				tick();
				if (!r_valid)
					report("r_valid dropped while r_ready was low");
				check_r(r_beat, exp);
			end
			r_ready = 1'b1;
			tick();
			r_ready = 1'b0;
			if (r_valid)
				report("r_valid did not drop after the beat was taken");
			else if (r_beat.data !== '0)
				report($sformatf("read data %h while r_valid was low", r_beat.data));
			a = step_addr(a, cmd.len, cmd.burst);
		end
	endtask

	// ----------------------------------------------------------------------
	// Directed tests
	// ----------------------------------------------------------------------
	task automatic reset_test();
		if (aw_ready || w_ready || b_valid || ar_ready || r_valid)
			report("a ready or valid output was high right after reset");
		check_mem(memory_out);
	endtask

	task automatic incr_test();
		for (int i = 0; i < 4; i++)
		begin
			rand_word(wr_data[i]);
			wr_strb[i] = '1;
		end
		write_burst(make_cmd(1'b1, '0, 8'd3, `CFG_BURST_INCR));
		check_mem(memory_out);
		read_burst(make_cmd(1'b0, '0, 8'd3, `CFG_BURST_INCR), 0);
	endtask

	// Three beats on row 1 with overlapping lanes
	task automatic fixed_test();
		for (int i = 0; i < 3; i++)
			rand_word(wr_data[i]);
		wr_strb[0] = 16'hffff;
		wr_strb[1] = 16'h00ff;
		wr_strb[2] = 16'h0f0f;
		write_burst(make_cmd(1'b0, 40'h10, 8'd2, `CFG_BURST_FIXED));
		check_mem(memory_out);
	endtask

	// Start at row 2 and wrap through rows 3, 0 and 1
	task automatic wrap_test();
		read_burst(make_cmd(1'b1, 40'h20, 8'd3, `CFG_BURST_WRAP), 0);
	endtask

	task automatic status_test();
		read_burst(make_cmd(1'b1, 40'h40, 8'd0, `CFG_BURST_INCR), 0);
		rand_word(wr_data[0]);
		wr_strb[0] = '1;
		write_burst(make_cmd(1'b1, 40'h40, 8'd0, `CFG_BURST_INCR));
		check_mem(memory_out);
	endtask

	task automatic backpressure_test();
		read_burst(make_cmd(1'b0, 40'h10, 8'd1, `CFG_BURST_INCR), 4);
	endtask

	// Both addresses together so the write must finish first
	task automatic ordering_test();
		for (int i = 0; i < 2; i++)
		begin
			rand_word(wr_data[i]);
			wr_strb[i] = '1;
		end
		ar_cmd = '{id: 1'b1, addr: 40'h20, len: 8'd1, burst: `CFG_BURST_INCR};
		ar_valid = 1'b1;
		write_burst(make_cmd(1'b0, 40'h20, 8'd1, `CFG_BURST_INCR));
		check_mem(memory_out);
		read_burst(make_cmd(1'b1, 40'h20, 8'd1, `CFG_BURST_INCR), 0);
	endtask

	initial
	begin
		lfsr = 32'hefd9;
		aw_cmd = '0;
		aw_valid = 1'b0;
		w_beat = '0;
		w_valid = 1'b0;
		b_ready = 1'b0;
		ar_cmd = '0;
		ar_valid = 1'b0;
		r_ready = 1'b0;
		mem_model = '0;
		rand_word(status_in);
		S_AXI_ARESETN = 1'b0;
		repeat (10) @(posedge S_AXI_ACLK);
		#1;
		S_AXI_ARESETN = 1'b1;
		reset_test();
		incr_test();
		fixed_test();
		wrap_test();
		status_test();
		backpressure_test();
		ordering_test();
		$display("checks done, %0d errors", err_count);
		if (err_count == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: files.f
+incdir+common
common/cfg_port_pkg.sv
design/burst_addr_gen.sv
design/cfg_port_ctrl.sv
cfg_ram/cfg_ram.sv
design/cfg_port_top.sv
verif/tb_cfg_port.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the cfg_port testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal -f files.f --top-module tb_cfg_port
./obj_dir/Vtb_cfg_port | tee sim.log

if grep -qx "test passed" sim.log; then
	exit 0
fi
exit 1
